//--- build.f
hdl/lsu_conf_pkg.sv
hdl/lsu_pkg.sv
hdl/lsu_lrsc.sv
hdl/lsu_pipe.sv
hdl/lsu_data_ram.sv
hdl/lsu_top.sv
dv/lsu_tb.sv

//--- dv/lsu_tb.sv
// Testbench for the two-port load/store unit; compile with build.f, top module lsu_tb.
`timescale 1ns/1ps

module lsu_tb import lsu_conf_pkg::*, lsu_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int N_FILL       = 48;
  localparam int N_STLD       = 4;
  localparam int N_LRSC       = 21;
  localparam int N_RAND       = 100;
  localparam int N_REQ_TOTAL  = N_FILL + N_STLD + N_LRSC + LSU_INST_NUM * N_RAND;

  logic      i_clk;
  logic      i_reset_n;
  logic      i_req_valid  [LSU_INST_NUM];
  logic      o_req_ready  [LSU_INST_NUM];
  lsu_req_t  i_req        [LSU_INST_NUM];
  logic      o_resp_valid [LSU_INST_NUM];
  logic      i_resp_ready [LSU_INST_NUM];
  lsu_resp_t o_resp       [LSU_INST_NUM];

  // The reference model holds the memory, the reservation and the responses still owed per port.
  xdata_t    ref_mem [MEM_DEPTH];
  logic      resv_valid;
  paddr_t    resv_addr;
  lsu_resp_t exp_q [LSU_INST_NUM][$];
  tag_t      tag_cnt [LSU_INST_NUM];

  logic      bp_on;
  int        n_data_err;
  int        n_proto_err;

  lsu_top u_lsu_top (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_req        (i_req),
    .o_resp_valid (o_resp_valid),
    .i_resp_ready (i_resp_ready),
    .o_resp       (o_resp)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Response back-pressure. With bp_on set, each port drops ready about one cycle in four.
  initial begin
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      i_resp_ready[p] = 1'b1;
    end
    forever begin
      @(posedge i_clk);
      #1;
      for (int p = 0; p < LSU_INST_NUM; p++) begin
        i_resp_ready[p] = bp_on ? ($urandom_range(3) != 0) : 1'b1;
      end
    end
  end

  for (genvar p = 0; p < LSU_INST_NUM; p++) begin : g_chk
    // A response that is not yet taken must stay valid and unchanged.
    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_resp_valid[p] && !i_resp_ready[p] |=> o_resp_valid[p] && $stable(o_resp[p]))
      else begin
        n_proto_err++;
        $display("[FAIL] o_resp[%0d] not held while waiting: o_resp_valid %h, o_resp %h",
                 p, $sampled(o_resp_valid[p]), $sampled(o_resp[p]));
      end

    assert property (@(posedge i_clk) !i_reset_n |-> !o_req_ready[p] && !o_resp_valid[p])
      else begin
        n_proto_err++;
        $display("[FAIL] port %0d in reset: o_req_ready %h, o_resp_valid %h",
                 p, $sampled(o_req_ready[p]), $sampled(o_resp_valid[p]));
      end

    assert property (@(posedge i_clk) $rose(i_reset_n) |=> o_req_ready[p])
      else begin
        n_proto_err++;
        $display("[FAIL] o_req_ready[%0d] is %h in the first cycle after reset", p,
                 $sampled(o_req_ready[p]));
      end
  end

  // Checks each response against the model, then applies every accepted request to it.
  always @(posedge i_clk) begin : model_and_check
    lsu_resp_t exp;
    lsu_req_t  req;
    logic      held_valid;
    paddr_t    held_addr;
    logic      lr_taken;
    logic      sc_ok;
    if (i_reset_n) begin
      for (int p = 0; p < LSU_INST_NUM; p++) begin
        if (o_resp_valid[p] && i_resp_ready[p]) begin
          if (exp_q[p].size() == 0) begin
            n_proto_err++;
            $display("Port %0d returned a response that no request asked for.", p);
          end else begin
            exp = exp_q[p].pop_front();
            assert (o_resp[p].tag == exp.tag) else begin
              n_data_err++;
              $display("[FAIL] o_resp[%0d].tag: expected %h, got %h",
                       p, exp.tag, o_resp[p].tag);
            end
            assert (o_resp[p].rdata == exp.rdata) else begin
              n_data_err++;
              $display("[FAIL] o_resp[%0d].rdata (tag %h): expected %h, got %h",
                       p, exp.tag, exp.rdata, o_resp[p].rdata);
            end
          end
        end
      end
      // SCs compare against the reservation as it stood before this cycle.
      held_valid = resv_valid;
      held_addr  = resv_addr;
      lr_taken   = 1'b0;
      for (int p = 0; p < LSU_INST_NUM; p++) begin
        if (i_req_valid[p] && o_req_ready[p]) begin
          req       = i_req[p];
          exp.tag   = req.tag;
          exp.rdata = '0;
          case (req.op)
            LOAD: exp.rdata = ref_mem[req.paddr];
            STORE: ref_mem[req.paddr] = req.wdata;
            LR: begin
              exp.rdata = ref_mem[req.paddr];
              if (!lr_taken) begin
                resv_valid = 1'b1;
                resv_addr  = req.paddr;
                lr_taken   = 1'b1;
              end
            end
            default: begin
              sc_ok = held_valid && (held_addr == req.paddr);
              if (sc_ok) begin
                ref_mem[req.paddr] = req.wdata;
              end
              exp.rdata = sc_ok ? '0 : xdata_t'(1);
              if (!lr_taken) begin
                resv_valid = 1'b0;
              end
            end
          endcase
          exp_q[p].push_back(exp);
        end
      end
    end
  end

  // Holds a request on port p until it is accepted. Called 1 ns after a rising edge.
  task automatic issue_req(input int p, input lsu_op_e kind, input paddr_t addr,
                           input xdata_t wdata);
    i_req[p] = '{op: kind, paddr: addr, wdata: wdata, tag: tag_cnt[p]};
    tag_cnt[p]++;
    i_req_valid[p] = 1'b1;
    do begin
      @(posedge i_clk);
    end while (!o_req_ready[p]);
    #1;
    i_req_valid[p] = 1'b0;
  endtask

  task automatic wait_drain(input int p);
    while (exp_q[p].size() != 0) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic issue_and_wait(input int p, input lsu_op_e kind, input paddr_t addr,
                                input xdata_t wdata);
    issue_req(p, kind, addr, wdata);
    wait_drain(p);
  endtask

  // Every word gets a value built from its full address.
  task automatic fill_range(input int p, input paddr_t base, input int count);
    paddr_t addr;
    for (int i = 0; i < count; i++) begin
      addr = base + paddr_t'(i);
      issue_req(p, STORE, addr, {8'ha5, addr, ~addr, addr});
    end
  endtask

  task automatic random_traffic(input int p, input paddr_t base);
    lsu_op_e kind;
    paddr_t  addr;
    for (int i = 0; i < N_RAND; i++) begin
      kind = ($urandom_range(1) == 0) ? LOAD : STORE;
      addr = base + paddr_t'($urandom_range(15));
      issue_req(p, kind, addr, $urandom());
      if ($urandom_range(3) == 0) begin
        @(posedge i_clk);
        #1;
      end
    end
  endtask

  initial begin : watchdog
    repeat (RESET_CYCLES + N_REQ_TOTAL * 40) @(posedge i_clk);
    $display("Timeout: the tests did not finish in %0d cycles.",
             RESET_CYCLES + N_REQ_TOTAL * 40);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    void'($urandom(22));
    i_reset_n   = 1'b0;
    bp_on       = 1'b0;
    resv_valid  = 1'b0;
    resv_addr   = '0;
    n_data_err  = 0;
    n_proto_err = 0;
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      i_req_valid[p] = 1'b0;
      i_req[p]       = '0;
      tag_cnt[p]     = '0;
    end
    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    bp_on     = 1'b1;

    // Port 0 owns 0x00-0x0F and 0x40-0x47, port 1 owns 0x10-0x1F and 0x48-0x4F.
    fork
      begin
        fill_range(0, 8'h00, 16);
        fill_range(0, 8'h40, 8);
        issue_req(0, STORE, 8'h05, 32'hcafe_0005);
        issue_req(0, LOAD, 8'h05, '0);
      end
      begin
        fill_range(1, 8'h10, 16);
        fill_range(1, 8'h48, 8);
        issue_req(1, STORE, 8'h15, 32'hbeef_0015);
        issue_req(1, LOAD, 8'h15, '0);
      end
    join
    wait_drain(0);
    wait_drain(1);

    // LR/SC runs without back-pressure, one request at a time.
    bp_on = 1'b0;
    issue_and_wait(0, SC, 8'h43, 32'h0bad_0043);
    issue_and_wait(0, LOAD, 8'h43, '0);
    issue_and_wait(0, LR, 8'h40, '0);
    issue_and_wait(0, SC, 8'h40, 32'h1111_0040);
    issue_and_wait(0, LOAD, 8'h40, '0);
    issue_and_wait(0, SC, 8'h40, 32'h2222_0040);
    issue_and_wait(0, LOAD, 8'h40, '0);
    issue_and_wait(0, LR, 8'h41, '0);
    issue_and_wait(0, SC, 8'h42, 32'h3333_0042);
    issue_and_wait(0, LOAD, 8'h42, '0);
    issue_and_wait(0, LR, 8'h44, '0);
    issue_and_wait(1, SC, 8'h44, 32'h4444_0044);
    issue_and_wait(1, LOAD, 8'h44, '0);
    issue_and_wait(0, LR, 8'h45, '0);
    issue_and_wait(0, LR, 8'h46, '0);
    issue_and_wait(0, SC, 8'h45, 32'h5555_0045);
    issue_and_wait(0, LOAD, 8'h45, '0);
    fork
      issue_req(0, LR, 8'h47, '0);
      issue_req(1, LR, 8'h48, '0);
    join
    wait_drain(0);
    wait_drain(1);
    issue_and_wait(1, SC, 8'h47, 32'h6666_0047);
    issue_and_wait(0, LOAD, 8'h47, '0);

    bp_on = 1'b1;
    fork
      random_traffic(0, 8'h00);
      random_traffic(1, 8'h10);
    join
    wait_drain(0);
    wait_drain(1);

    $display("Errors: %0d data, %0d protocol", n_data_err, n_proto_err);
    if (n_data_err == 0 && n_proto_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- hdl/lsu_top.sv
// Top level of the two-port load/store unit; connects the pipes to the shared memory and reservation block.
`timescale 1ns/1ps

module lsu_top import lsu_conf_pkg::*, lsu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset_n,

  // Request handshake, one entry per port.
  input  logic      i_req_valid  [LSU_INST_NUM],
  output logic      o_req_ready  [LSU_INST_NUM],
  input  lsu_req_t  i_req        [LSU_INST_NUM],

  // Response handshake, one entry per port.
  output logic      o_resp_valid [LSU_INST_NUM],
  input  logic      i_resp_ready [LSU_INST_NUM],
  output lsu_resp_t o_resp       [LSU_INST_NUM]
);

  lrsc_req_t w_lrsc_req [LSU_INST_NUM];
  logic      w_sc_success;

  logic      w_mem_en    [LSU_INST_NUM];
  logic      w_mem_we    [LSU_INST_NUM];
  paddr_t    w_mem_addr  [LSU_INST_NUM];
  xdata_t    w_mem_wdata [LSU_INST_NUM];
  xdata_t    w_mem_rdata [LSU_INST_NUM];

  for (genvar p = 0; p < LSU_INST_NUM; p++) begin : u_pipe
    lsu_pipe u_lsu_pipe (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_req_valid  (i_req_valid[p]),
      .o_req_ready  (o_req_ready[p]),
      .i_req        (i_req[p]),
      .o_resp_valid (o_resp_valid[p]),
      .i_resp_ready (i_resp_ready[p]),
      .o_resp       (o_resp[p]),
      .o_lrsc_req   (w_lrsc_req[p]),
      .i_sc_success (w_sc_success),
      .o_mem_en     (w_mem_en[p]),
      .o_mem_we     (w_mem_we[p]),
      .o_mem_addr   (w_mem_addr[p]),
      .o_mem_wdata  (w_mem_wdata[p]),
      .i_mem_rdata  (w_mem_rdata[p])
    );
  end

  // The one reservation is shared, so its result goes back to every pipe.
  lsu_lrsc u_lrsc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_lrsc_req   (w_lrsc_req),
    .o_sc_success (w_sc_success)
  );

  lsu_data_ram u_ram (
    .i_clk   (i_clk),
    .i_en    (w_mem_en),
    .i_we    (w_mem_we),
    .i_addr  (w_mem_addr),
    .i_wdata (w_mem_wdata),
    .o_rdata (w_mem_rdata)
  );

endmodule

//--- hdl/lsu_data_ram.sv
// Dual-port synchronous data memory shared by the load/store pipes, with one port per pipe.
`timescale 1ns/1ps

module lsu_data_ram import lsu_conf_pkg::*, lsu_pkg::*; (
  input  logic   i_clk,
  input  logic   i_en    [LSU_INST_NUM],
  input  logic   i_we    [LSU_INST_NUM],
  input  paddr_t i_addr  [LSU_INST_NUM],
  input  xdata_t i_wdata [LSU_INST_NUM],
  output xdata_t o_rdata [LSU_INST_NUM]
);

  xdata_t r_mem [MEM_DEPTH];

  xdata_t r_rdata [LSU_INST_NUM];

  // Write strobe after the collision rule has been applied.
  logic   w_wr [LSU_INST_NUM];

  // A port's write is dropped when a higher-numbered port writes the same word
  // in the same cycle. With two ports this means port 1 wins.
  always_comb begin
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      w_wr[p] = i_en[p] & i_we[p];
      for (int q = p + 1; q < LSU_INST_NUM; q++) begin
        if (i_en[q] && i_we[q] && (i_addr[q] == i_addr[p])) begin
          w_wr[p] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      if (w_wr[p]) begin
        r_mem[i_addr[p]] <= i_wdata[p];
      end
    end
  end

  // Reads are registered and sample the array before this cycle's writes land.
  // When a port is idle its last read word is held.
  for (genvar p = 0; p < LSU_INST_NUM; p++) begin : g_rd
    always_ff @(posedge i_clk) begin
      if (i_en[p]) begin
        r_rdata[p] <= r_mem[i_addr[p]];
      end
    end

    assign o_rdata[p] = r_rdata[p];
  end

endmodule

//--- hdl/lsu_pipe.sv
// One port's two-stage load/store pipeline; lsu_top instantiates one per port in front of the shared memory.
`timescale 1ns/1ps

module lsu_pipe import lsu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset_n,

  // Request side.
  input  logic      i_req_valid,
  output logic      o_req_ready,
  input  lsu_req_t  i_req,

  // Response side.
  output logic      o_resp_valid,
  input  logic      i_resp_ready,
  output lsu_resp_t o_resp,

  // Reservation block.
  output lrsc_req_t o_lrsc_req,
  input  logic      i_sc_success,

  // This port's memory port.
  output logic      o_mem_en,
  output logic      o_mem_we,
  output paddr_t    o_mem_addr,
  output xdata_t    o_mem_wdata,
  input  xdata_t    i_mem_rdata
);

  // Goes high one cycle after reset is released and opens the request side.
  logic     r_run;

  // Execute stage.
  logic     r_ex_valid;
  lsu_req_t r_ex_req;

  // Response stage.
  logic     r_resp_valid;
  lsu_op_e  r_resp_op;
  tag_t     r_resp_tag;
  logic     r_resp_sc_fail;

  logic     w_req_fire;
  logic     w_ex_advance;
  logic     w_ex_is_lr;
  logic     w_ex_is_sc;
  logic     w_ex_is_store;

  // The execute stage moves on only when the response stage is empty or is
  // being drained in this same cycle. Everything the stage does to memory and
  // to the reservation is tied to this signal, so a stall repeats nothing.
  assign w_ex_advance = r_ex_valid & (~r_resp_valid | i_resp_ready);

  // A new request fits when the execute stage is empty or is leaving.
  assign o_req_ready = r_run & (~r_ex_valid | w_ex_advance);
  assign w_req_fire  = i_req_valid & o_req_ready;

  assign w_ex_is_lr    = (r_ex_req.op == LR);
  assign w_ex_is_sc    = (r_ex_req.op == SC);
  assign w_ex_is_store = (r_ex_req.op == STORE);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_run        <= 1'b0;
      r_ex_valid   <= 1'b0;
      r_resp_valid <= 1'b0;
    end else begin
      r_run <= 1'b1;

      if (w_req_fire) begin
        r_ex_valid <= 1'b1;
      end else if (w_ex_advance) begin
        r_ex_valid <= 1'b0;
      end

      if (w_ex_advance) begin
        r_resp_valid <= 1'b1;
      end else if (i_resp_ready) begin
        r_resp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_req_fire) begin
      r_ex_req <= i_req;
    end
    if (w_ex_advance) begin
      r_resp_op      <= r_ex_req.op;
      r_resp_tag     <= r_ex_req.tag;
      r_resp_sc_fail <= ~i_sc_success;
    end
  end

  // Reservation actions, raised only in the cycle the stage advances.
  assign o_lrsc_req.lr_update_valid = w_ex_advance & w_ex_is_lr;
  assign o_lrsc_req.sc_check_valid  = w_ex_advance & w_ex_is_sc;
  assign o_lrsc_req.paddr           = r_ex_req.paddr;

  // Every request touches memory once. LOAD and LR read, STORE writes, and an
  // SC writes only when the reservation check passes in the same cycle.
  assign o_mem_en    = w_ex_advance;
  assign o_mem_we    = w_ex_advance & (w_ex_is_store | (w_ex_is_sc & i_sc_success));
  assign o_mem_addr  = r_ex_req.paddr;
  assign o_mem_wdata = r_ex_req.wdata;

  assign o_resp_valid = r_resp_valid;
  assign o_resp.tag   = r_resp_tag;

  // The memory holds its read data while this port issues nothing, and the
  // port issues nothing while a response waits, so rdata stays stable.
  always_comb begin
    o_resp.rdata = '0;
    case (r_resp_op)
      LOAD:    o_resp.rdata = i_mem_rdata;
      LR:      o_resp.rdata = i_mem_rdata;
      SC:      o_resp.rdata = xdata_t'(r_resp_sc_fail);
      STORE:   o_resp.rdata = '0;
      default: o_resp.rdata = '0;
    endcase
  end

endmodule

//--- hdl/lsu_lrsc.sv
// Shared LR/SC reservation register; every pipe sends its LR and SC actions here and reads back the SC result.
`timescale 1ns/1ps

module lsu_lrsc import lsu_conf_pkg::*, lsu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  lrsc_req_t i_lrsc_req [LSU_INST_NUM],
  output logic      o_sc_success
);

  logic   r_resv_valid;
  paddr_t r_resv_paddr;

  logic   w_lr_any;
  logic   w_sc_any;
  paddr_t w_lr_paddr;
  paddr_t w_sc_paddr;

  // Priority select over the ports. The loop runs from the highest index down,
  // so the lowest port that raises a flag is the one whose address is kept.
  always_comb begin
    w_lr_any   = 1'b0;
    w_sc_any   = 1'b0;
    w_lr_paddr = '0;
    w_sc_paddr = '0;
    for (int p = LSU_INST_NUM - 1; p >= 0; p--) begin
      if (i_lrsc_req[p].lr_update_valid) begin
        w_lr_any   = 1'b1;
        w_lr_paddr = i_lrsc_req[p].paddr;
      end
      if (i_lrsc_req[p].sc_check_valid) begin
        w_sc_any   = 1'b1;
        w_sc_paddr = i_lrsc_req[p].paddr;
      end
    end
  end

  // An LR anywhere sets the reservation, and it beats an SC in the same cycle.
  // Any SC, whether it passes or not, drops the reservation.
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resv_valid <= 1'b0;
    end else if (w_lr_any) begin
      r_resv_valid <= 1'b1;
    end else if (w_sc_any) begin
      r_resv_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_lr_any) begin
      r_resv_paddr <= w_lr_paddr;
    end
  end

  // The check uses the reservation as it stood at the start of the cycle, so
  // an LR in the same cycle cannot make an SC pass.
  assign o_sc_success = r_resv_valid & (r_resv_paddr == w_sc_paddr);

endmodule

//--- hdl/lsu_pkg.sv
// Types shared by the load/store unit modules: addresses, data, opcodes, requests and responses.
package lsu_pkg;

  import lsu_conf_pkg::*;

  // Word address into the shared data memory.
  typedef logic [PADDR_W-1:0] paddr_t;

  // One data word.
  typedef logic [XLEN-1:0] xdata_t;

  // Request tag, returned unchanged with the response.
  typedef logic [TAG_W-1:0] tag_t;

  // Request kinds. LR and SC follow the RISC-V load-reserved and store-conditional rules.
  typedef enum logic [1:0] {
    LOAD  = 2'd0,
    STORE = 2'd1,
    LR    = 2'd2,
    SC    = 2'd3
  } lsu_op_e;

  // One request as it arrives on a port.
  typedef struct packed {
    lsu_op_e op;
    paddr_t  paddr;
    xdata_t  wdata;
    tag_t    tag;
  } lsu_req_t;

  // One response. For LOAD and LR rdata is the memory word, for SC it is 0 on
  // success and 1 on failure, and for STORE it is zero.
  typedef struct packed {
    xdata_t rdata;
    tag_t   tag;
  } lsu_resp_t;

  // What a pipe tells the reservation block in the cycle its execute stage advances.
  typedef struct packed {
    logic   lr_update_valid;
    logic   sc_check_valid;
    paddr_t paddr;
  } lrsc_req_t;

endpackage

//--- hdl/lsu_conf_pkg.sv
// Sizing constants for the two-port load/store unit; import it wherever a width or a count is needed.
package lsu_conf_pkg;

  // Number of load/store ports that share the data memory and the reservation.
  localparam int LSU_INST_NUM = 2;

  // Word-address width. Addresses count whole words, never bytes.
  localparam int PADDR_W = 8;

  // Data word width.
  localparam int XLEN = 32;

  // Width of the request tag that is echoed back in the response.
  localparam int TAG_W = 4;

  // One memory word for every word address.
  localparam int MEM_DEPTH = 1 << PADDR_W;

endpackage
